// File: logic/pwm_cmd_pkg.sv
package pwm_cmd_pkg;

    // command opcodes carried in the top two bits of every command word
    typedef enum logic [1:0] {
        OP_MUL  = 2'd0,
        OP_MAC  = 2'd1,
        OP_SEED = 2'd2
    } opcode_e;

    // width of the tag that travels with an operation and comes back with its result
    localparam int TAG_W = 8;

    // compute view, the bits between opcode and tag are reserved and sent as zero
    typedef struct packed {
        opcode_e                op;
        logic [31-2-TAG_W:0]    rsvd;
        logic [TAG_W-1:0]       tag;
    } cmd_compute_s;

    // seed view, everything below the opcode is fresh seed material for the mask generator
    typedef struct packed {
        opcode_e        op;
        logic [29:0]    seed;
    } cmd_seed_s;

    // the opcode sits in the same place in both views so either one can be used to pick the view
    typedef union packed {
        cmd_compute_s   compute;
        cmd_seed_s      seed;
    } pwm_cmd_u;

endpackage

// File: logic/pwm_arith_pkg.sv
package pwm_arith_pkg;

    // share width, arithmetic is done modulo 2^DEFAULT_WIDTH
    localparam int DEFAULT_WIDTH = 24;

    // multiplier stages from issue to product shares, two is the minimum
    localparam int DEFAULT_MULT_LATENCY = 3;

    // result queue entries, also the limit on operations in flight
    localparam int DEFAULT_RES_DEPTH = 4;

    // mask words produced every cycle
    // words 0 and 1 refresh the multiplier cross terms and word 2 refreshes the adder output
    localparam int N_RND = 3;

endpackage

// File: logic/pwm_ifs.sv
`timescale 1ns/1ps

// operand or product shares moving down the pipeline, valid is a single-cycle pulse
interface pwm_share_if #(
    parameter int WIDTH = pwm_arith_pkg::DEFAULT_WIDTH
);
    logic                           valid;
    logic [WIDTH-1:0]               a0;
    logic [WIDTH-1:0]               a1;
    logic [WIDTH-1:0]               b0;
    logic [WIDTH-1:0]               b1;
    logic [WIDTH-1:0]               c0;
    logic [WIDTH-1:0]               c1;
    logic [pwm_cmd_pkg::TAG_W-1:0]  tag;

    modport src (output valid, a0, a1, b0, b1, c0, c1, tag);
    modport dst (input valid, a0, a1, b0, b1, c0, c1, tag);
endinterface

// finished result shares on their way into the result queue
interface pwm_result_if #(
    parameter int WIDTH = pwm_arith_pkg::DEFAULT_WIDTH
);
    logic                           valid;
    logic [WIDTH-1:0]               res0;
    logic [WIDTH-1:0]               res1;
    logic [pwm_cmd_pkg::TAG_W-1:0]  tag;

    modport src (output valid, res0, res1, tag);
    modport dst (input valid, res0, res1, tag);
endinterface

// File: logic/pwm_decode.sv
`timescale 1ns/1ps

module pwm_decode #(
    parameter int WIDTH     = pwm_arith_pkg::DEFAULT_WIDTH,
    parameter int RES_DEPTH = pwm_arith_pkg::DEFAULT_RES_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_req,
    output logic                cmd_ack,
    input  logic [31:0]         cmd_word,
    input  logic [WIDTH-1:0]    u0,
    input  logic [WIDTH-1:0]    u1,
    input  logic [WIDTH-1:0]    v0,
    input  logic [WIDTH-1:0]    v1,
    input  logic [WIDTH-1:0]    w0,
    input  logic [WIDTH-1:0]    w1,
    input  logic                res_pop,
    output logic                seed_load,
    output logic [29:0]         seed,
    pwm_share_if.src            issue
);
    localparam int CNT_W = $clog2(RES_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(RES_DEPTH);

    pwm_cmd_pkg::pwm_cmd_u  cmd;
    logic                   is_seed;
    logic                   is_mac;
    logic                   is_compute;
    logic                   accept;
    logic                   issue_fire;
    logic [CNT_W-1:0]       in_flight;

    assign cmd = cmd_word;

    // the opcode is read through the seed view for reseeding and through the compute view otherwise
    assign is_seed    = cmd.seed.op == pwm_cmd_pkg::OP_SEED;
    assign is_mac     = cmd.compute.op == pwm_cmd_pkg::OP_MAC;
    assign is_compute = is_mac || (cmd.compute.op == pwm_cmd_pkg::OP_MUL);

    // a new request is only ever seen while ack is low, since ack falls after req has fallen
    // compute commands wait for a free result slot, anything else is taken at once
    // an unused opcode is acknowledged and simply dropped
    assign accept     = cmd_req && !cmd_ack && (!is_compute || in_flight != FULL);
    assign issue_fire = accept && is_compute;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ack     <= 1'b0;
            issue.valid <= 1'b0;
            seed_load   <= 1'b0;
            in_flight   <= '0;
        end else begin
            // the issue pulse and the rising ack share the same edge
            issue.valid <= issue_fire;
            seed_load   <= accept && is_seed;
            if (accept) begin
                cmd_ack <= 1'b1;
            end else if (cmd_ack && !cmd_req) begin
                cmd_ack <= 1'b0;
            end
            // one slot per operation from issue until the queue gives its entry away
            case ({issue_fire, res_pop})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // operand shares are captured with the command, w is forced to zero for a plain multiply
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue.a0  <= u0;
            issue.a1  <= u1;
            issue.b0  <= v0;
            issue.b1  <= v1;
            issue.c0  <= is_mac ? w0 : '0;
            issue.c1  <= is_mac ? w1 : '0;
            issue.tag <= cmd.compute.tag;
        end
        if (accept && is_seed) begin
            seed <= cmd.seed.seed;
        end
    end

endmodule

// File: logic/mask_rng.sv
`timescale 1ns/1ps

module mask_rng #(
    parameter int WIDTH = pwm_arith_pkg::DEFAULT_WIDTH
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        seed_load,
    input  logic [29:0]                                 seed,
    output logic [pwm_arith_pkg::N_RND-1:0][WIDTH-1:0]  rnd
);
    localparam int N_BITS = pwm_arith_pkg::N_RND * WIDTH;

    // x^32 + x^22 + x^2 + x + 1 in right-shifting Galois form
    localparam logic [31:0] TAPS        = 32'h8020_0003;
    localparam logic [31:0] RESET_STATE = 32'h1d87_2b41;

    logic [31:0]        state;
    logic [31:0]        state_next;
    logic [N_BITS-1:0]  keystream;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ ({32{s[0]}} & TAPS);
    endfunction

    // one output bit per step, so every mask bit in a cycle comes from a distinct step
    // the whole chain is linear and flattens into an XOR network
    always_comb begin
        logic [31:0] s;
        s = state;
        for (int i = 0; i < N_BITS; i++) begin
            keystream[i] = s[0];
            s = lfsr_step(s);
        end
        state_next = s;
    end

    assign rnd = keystream;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RESET_STATE;
        end else if (seed_load) begin
            // bit 0 is forced high so a loaded seed can never lock the register at zero
            state <= {2'b00, seed[29:1], 1'b1};
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: logic/masked_mult.sv
`timescale 1ns/1ps

module masked_mult #(
    parameter int WIDTH        = pwm_arith_pkg::DEFAULT_WIDTH,
    parameter int MULT_LATENCY = pwm_arith_pkg::DEFAULT_MULT_LATENCY
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [1:0][WIDTH-1:0]   rnd,
    pwm_share_if.dst                op_in,
    pwm_share_if.src                op_out
);
    localparam int TAG_W = pwm_cmd_pkg::TAG_W;

    // stage 1 holds the four partial-product groups and the w shares beside them
    logic [WIDTH-1:0]   g00;
    logic [WIDTH-1:0]   g01;
    logic [WIDTH-1:0]   g10;
    logic [WIDTH-1:0]   g11;
    logic [WIDTH-1:0]   w0_s1;
    logic [WIDTH-1:0]   w1_s1;
    logic [TAG_W-1:0]   tag_s1;

    // stage 2 onward, index k is the register at the end of stage k
    logic [WIDTH-1:0]   p0_q  [2:MULT_LATENCY];
    logic [WIDTH-1:0]   p1_q  [2:MULT_LATENCY];
    logic [WIDTH-1:0]   x0_q  [2:MULT_LATENCY];
    logic [WIDTH-1:0]   x1_q  [2:MULT_LATENCY];
    logic [WIDTH-1:0]   c0_q  [2:MULT_LATENCY];
    logic [WIDTH-1:0]   c1_q  [2:MULT_LATENCY];
    logic [TAG_W-1:0]   tag_q [2:MULT_LATENCY];
    logic [MULT_LATENCY:1] vld_q;

    always_ff @(posedge clk) begin
        // each share keeps its own product, the two cross terms are hidden under fresh masks
        // r0 moves from group 00 to group 01 and r1 from group 11 to group 10
        g00    <= op_in.a0 * op_in.b0 - rnd[0];
        g01    <= op_in.a0 * op_in.b1 + rnd[0];
        g10    <= op_in.a1 * op_in.b0 + rnd[1];
        g11    <= op_in.a1 * op_in.b1 - rnd[1];
        w0_s1  <= op_in.c0;
        w1_s1  <= op_in.c1;
        tag_s1 <= op_in.tag;

        // fold the groups so that no share ever combines two unmasked cross terms
        p0_q[2]  <= g00 + g10;
        p1_q[2]  <= g11 + g01;
        x0_q[2]  <= g01;
        x1_q[2]  <= g10;
        c0_q[2]  <= w0_s1;
        c1_q[2]  <= w1_s1;
        tag_q[2] <= tag_s1;

        // remaining stages only delay, this loop is empty when MULT_LATENCY is 2
        for (int k = 3; k <= MULT_LATENCY; k++) begin
            p0_q[k]  <= p0_q[k-1];
            p1_q[k]  <= p1_q[k-1];
            x0_q[k]  <= x0_q[k-1];
            x1_q[k]  <= x1_q[k-1];
            c0_q[k]  <= c0_q[k-1];
            c1_q[k]  <= c1_q[k-1];
            tag_q[k] <= tag_q[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MULT_LATENCY-1:1], op_in.valid};
        end
    end

    assign op_out.valid = vld_q[MULT_LATENCY];
    assign op_out.a0    = p0_q[MULT_LATENCY];
    assign op_out.a1    = p1_q[MULT_LATENCY];
    // the adder ignores b, it carries the masked cross groups for observation
    assign op_out.b0    = x0_q[MULT_LATENCY];
    assign op_out.b1    = x1_q[MULT_LATENCY];
    assign op_out.c0    = c0_q[MULT_LATENCY];
    assign op_out.c1    = c1_q[MULT_LATENCY];
    assign op_out.tag   = tag_q[MULT_LATENCY];

endmodule

// File: logic/masked_add.sv
`timescale 1ns/1ps

module masked_add #(
    parameter int WIDTH = pwm_arith_pkg::DEFAULT_WIDTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [WIDTH-1:0]    rnd,
    pwm_share_if.dst            prod,
    pwm_result_if.src           res
);

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= prod.valid;
        end
    end

    // shares are summed one by one and never recombined
    // the mask enters share 0 and leaves share 1, so the result pair is fresh but sums the same
    always_ff @(posedge clk) begin
        res.res0 <= prod.a0 + prod.c0 + rnd;
        res.res1 <= prod.a1 + prod.c1 - rnd;
        res.tag  <= prod.tag;
    end

endmodule

// File: logic/pwm_result.sv
`timescale 1ns/1ps

module pwm_result #(
    parameter int WIDTH     = pwm_arith_pkg::DEFAULT_WIDTH,
    parameter int RES_DEPTH = pwm_arith_pkg::DEFAULT_RES_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst,
    pwm_result_if.dst                       res_in,
    output logic                            res_req,
    input  logic                            res_ack,
    output logic [WIDTH-1:0]                res0,
    output logic [WIDTH-1:0]                res1,
    output logic [pwm_cmd_pkg::TAG_W-1:0]   res_tag,
    output logic                            res_pop
);
    localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
    localparam int CNT_W = $clog2(RES_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(RES_DEPTH - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_RELEASE
    } state_e;

    logic [WIDTH-1:0]               q0   [RES_DEPTH];
    logic [WIDTH-1:0]               q1   [RES_DEPTH];
    logic [pwm_cmd_pkg::TAG_W-1:0]  qtag [RES_DEPTH];
    logic [PTR_W-1:0]               wr_ptr;
    logic [PTR_W-1:0]               rd_ptr;
    logic [CNT_W-1:0]               q_cnt;
    state_e                         state;

    // the head entry stays put for as long as the request is up
    assign res0    = q0[rd_ptr];
    assign res1    = q1[rd_ptr];
    assign res_tag = qtag[rd_ptr];
    assign res_req = state == S_REQ;
    assign res_pop = (state == S_REQ) && res_ack;

    // no full check here, the decoder never lets more than RES_DEPTH operations in flight
    always_ff @(posedge clk) begin
        if (res_in.valid) begin
            q0[wr_ptr]   <= res_in.res0;
            q1[wr_ptr]   <= res_in.res1;
            qtag[wr_ptr] <= res_in.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
            state  <= S_IDLE;
        end else begin
            if (res_in.valid) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (res_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({res_in.valid, res_pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
            case (state)
                // an entry being written this cycle is already the head in the next one
                S_IDLE: if (q_cnt != '0 || res_in.valid) state <= S_REQ;
                S_REQ: if (res_ack) state <= S_RELEASE;
                // the next request waits for the slave to drop its ack
                S_RELEASE: if (!res_ack) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: logic/masked_pwm_top.sv
`timescale 1ns/1ps

module masked_pwm_top #(
    parameter int WIDTH        = pwm_arith_pkg::DEFAULT_WIDTH,
    parameter int MULT_LATENCY = pwm_arith_pkg::DEFAULT_MULT_LATENCY,
    parameter int RES_DEPTH    = pwm_arith_pkg::DEFAULT_RES_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_req,
    output logic                            cmd_ack,
    input  logic [31:0]                     cmd_word,
    input  logic [WIDTH-1:0]                u0,
    input  logic [WIDTH-1:0]                u1,
    input  logic [WIDTH-1:0]                v0,
    input  logic [WIDTH-1:0]                v1,
    input  logic [WIDTH-1:0]                w0,
    input  logic [WIDTH-1:0]                w1,
    output logic                            res_req,
    input  logic                            res_ack,
    output logic [WIDTH-1:0]                res0,
    output logic [WIDTH-1:0]                res1,
    output logic [pwm_cmd_pkg::TAG_W-1:0]   res_tag
);
    logic [pwm_arith_pkg::N_RND-1:0][WIDTH-1:0] rnd;
    logic                                       seed_load;
    logic [29:0]                                seed;
    logic                                       res_pop;

    pwm_share_if  #(.WIDTH(WIDTH)) issue_bus ();
    pwm_share_if  #(.WIDTH(WIDTH)) prod_bus ();
    pwm_result_if #(.WIDTH(WIDTH)) result_bus ();

    // command slave, back-pressure and issue
    pwm_decode #(
        .WIDTH     (WIDTH),
        .RES_DEPTH (RES_DEPTH)
    ) u_pwm_decode (
        .clk       (clk),
        .rst       (rst),
        .cmd_req   (cmd_req),
        .cmd_ack   (cmd_ack),
        .cmd_word  (cmd_word),
        .u0        (u0),
        .u1        (u1),
        .v0        (v0),
        .v1        (v1),
        .w0        (w0),
        .w1        (w1),
        .res_pop   (res_pop),
        .seed_load (seed_load),
        .seed      (seed),
        .issue     (issue_bus.src)
    );

    mask_rng #(
        .WIDTH (WIDTH)
    ) u_mask_rng (
        .clk       (clk),
        .rst       (rst),
        .seed_load (seed_load),
        .seed      (seed),
        .rnd       (rnd)
    );

    // mask words 0 and 1 go to the multiplier and word 2 to the adder
    masked_mult #(
        .WIDTH        (WIDTH),
        .MULT_LATENCY (MULT_LATENCY)
    ) u_masked_mult (
        .clk    (clk),
        .rst    (rst),
        .rnd    (rnd[1:0]),
        .op_in  (issue_bus.dst),
        .op_out (prod_bus.src)
    );

    masked_add #(
        .WIDTH (WIDTH)
    ) u_masked_add (
        .clk  (clk),
        .rst  (rst),
        .rnd  (rnd[2]),
        .prod (prod_bus.dst),
        .res  (result_bus.src)
    );

    pwm_result #(
        .WIDTH     (WIDTH),
        .RES_DEPTH (RES_DEPTH)
    ) u_pwm_result (
        .clk     (clk),
        .rst     (rst),
        .res_in  (result_bus.dst),
        .res_req (res_req),
        .res_ack (res_ack),
        .res0    (res0),
        .res1    (res1),
        .res_tag (res_tag),
        .res_pop (res_pop)
    );

endmodule

// File: test/masked_pwm_properties.sv
`timescale 1ns/1ps

module masked_pwm_properties #(
    parameter int WIDTH = pwm_arith_pkg::DEFAULT_WIDTH
) (
    input logic                             clk,
    input logic                             rst,
    input logic                             cmd_req,
    input logic                             cmd_ack,
    input logic                             res_req,
    input logic                             res_ack,
    input logic [WIDTH-1:0]                 res0,
    input logic [WIDTH-1:0]                 res1,
    input logic [pwm_cmd_pkg::TAG_W-1:0]    res_tag
);

    // the decoder only answers a request it has already seen
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose while cmd_req was low");

    // the head entry is frozen until the result slave takes it
    res_data_stable: assert property (@(posedge clk) disable iff (rst)
        (res_req && !res_ack) |=> $stable({res0, res1, res_tag}))
        else $error("result data changed while res_req waited for res_ack");

    // the result master comes out of reset idle
    res_idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !res_req)
        else $error("res_req was high in the first cycle after reset");

endmodule

bind masked_pwm_top masked_pwm_properties #(
    .WIDTH (WIDTH)
) u_masked_pwm_properties (
    .clk     (clk),
    .rst     (rst),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .res_req (res_req),
    .res_ack (res_ack),
    .res0    (res0),
    .res1    (res1),
    .res_tag (res_tag)
);

// File: test/masked_pwm_tb.sv
`timescale 1ns/1ps

module masked_pwm_tb;
    localparam int WIDTH   = pwm_arith_pkg::DEFAULT_WIDTH;
    localparam int TAG_W   = pwm_cmd_pkg::TAG_W;
    // sixteen records of nine words each in the vector file
    localparam int N_REC   = 16;
    localparam int N_COL   = 9;
    localparam int TIMEOUT = 100 + 40 * N_REC;

    logic               clk;
    logic               rst;
    logic               cmd_req;
    logic               cmd_ack;
    logic [31:0]        cmd_word;
    logic [WIDTH-1:0]   u0;
    logic [WIDTH-1:0]   u1;
    logic [WIDTH-1:0]   v0;
    logic [WIDTH-1:0]   v1;
    logic [WIDTH-1:0]   w0;
    logic [WIDTH-1:0]   w1;
    logic               res_req;
    logic               res_ack;
    logic [WIDTH-1:0]   res0;
    logic [WIDTH-1:0]   res1;
    logic [TAG_W-1:0]   res_tag;

    logic [31:0]        vec [0:N_REC*N_COL-1];
    logic [WIDTH-1:0]   exp_sum_q [$];
    logic [TAG_W-1:0]   exp_tag_q [$];
    int                 n_expected;
    int                 n_received;
    int                 cycles;
    integer             seed;
    logic               run_passed;
    logic               fail_reported;

    masked_pwm_top u_masked_pwm_top (
        .clk      (clk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .cmd_word (cmd_word),
        .u0       (u0),
        .u1       (u1),
        .v0       (v0),
        .v1       (v1),
        .w0       (w0),
        .w1       (w1),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .res0     (res0),
        .res1     (res1),
        .res_tag  (res_tag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error();
        fail_reported = 1'b1;
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // four-phase master for one record, returns once ack has dropped again
    task automatic send_command(input int r);
        int base;
        base = r * N_COL;
        @(posedge clk);
        cmd_word <= vec[base];
        u0       <= vec[base+1][WIDTH-1:0];
        u1       <= vec[base+2][WIDTH-1:0];
        v0       <= vec[base+3][WIDTH-1:0];
        v1       <= vec[base+4][WIDTH-1:0];
        w0       <= vec[base+5][WIDTH-1:0];
        w1       <= vec[base+6][WIDTH-1:0];
        cmd_req  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!cmd_ack);
        cmd_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (cmd_ack);
    endtask

    // results must come back in command order, one per compute record
    task automatic check_result();
        logic [WIDTH-1:0] got_sum;
        logic [WIDTH-1:0] exp_sum;
        logic [TAG_W-1:0] exp_tag;
        assert (exp_sum_q.size() > 0) else begin
            $display("a result with tag %h arrived after every compute command was answered",
                     res_tag);
            stop_on_error();
        end
        exp_sum = exp_sum_q.pop_front();
        exp_tag = exp_tag_q.pop_front();
        // the shares are random on their own, only their sum carries the value
        got_sum = res0 + res1;
        assert (res_tag == exp_tag) else begin
            $display("** Error: res_tag = %h, expected %h (result %0d)",
                     res_tag, exp_tag, n_received);
            stop_on_error();
        end
        assert (got_sum == exp_sum) else begin
            $display("** Error: res0 + res1 = %h, expected %h (res0 = %h, res1 = %h, tag %h)",
                     got_sum, exp_sum, res0, res1, res_tag);
            stop_on_error();
        end
        n_received++;
    endtask

    initial begin
        cmd_req       = 1'b0;
        cmd_word      = '0;
        u0            = '0;
        u1            = '0;
        v0            = '0;
        v1            = '0;
        w0            = '0;
        w1            = '0;
        rst           = 1'b1;
        run_passed    = 1'b0;
        fail_reported = 1'b0;
        n_expected    = 0;
        n_received    = 0;
        $readmemh("test/pwm_tests.mem", vec);
        // seed records produce nothing, every other record expects its sum and its tag back
        for (int r = 0; r < N_REC; r++) begin
            if (vec[r*N_COL+8] == 32'd0) begin
                exp_sum_q.push_back(vec[r*N_COL+7][WIDTH-1:0]);
                exp_tag_q.push_back(vec[r*N_COL][TAG_W-1:0]);
                n_expected++;
            end
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < N_REC; r++) begin
            send_command(r);
        end
        while (n_received < n_expected) begin
            @(posedge clk);
        end
        // quiet stretch where a stray result for a seed command or a duplicate would show up
        repeat (20) @(posedge clk);
        if (!res_req) begin
            run_passed = 1'b1;
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("a result was still pending after all expected results had arrived");
            stop_on_error();
        end
    end

    // result slave with a random acknowledge delay
    initial begin
        int delay;
        res_ack = 1'b0;
        seed    = 32'h5183a978;
        @(negedge rst);
        forever begin
            @(posedge clk);
            if (res_req && !res_ack) begin
                check_result();
                delay = $unsigned($random(seed)) % 13;
                // the fourth to ninth results are held back so the queue fills and ack is withheld
                if (n_received >= 4 && n_received <= 9) begin
                    delay = 12;
                end
                repeat (delay) @(posedge clk);
                res_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (res_req);
                res_ack <= 1'b0;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout after %0d cycles with %0d of %0d results received",
                         cycles, n_received, n_expected);
                stop_on_error();
            end
        end
    end

    // a run cut short by a bound property still ends with a verdict
    final begin
        if (!run_passed && !fail_reported) begin
            $display("=== FAIL ===");
        end
    end

endmodule

// File: masked_pwm.f
logic/pwm_cmd_pkg.sv
logic/pwm_arith_pkg.sv
logic/pwm_ifs.sv
logic/pwm_decode.sv
logic/mask_rng.sv
logic/masked_mult.sv
logic/masked_add.sv
logic/pwm_result.sv
logic/masked_pwm_top.sv
test/masked_pwm_properties.sv
test/masked_pwm_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and decides pass or fail from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module masked_pwm_tb -f masked_pwm.f -o masked_pwm_sim \
    && ./obj_dir/masked_pwm_sim 2>&1 | tee "$log" \
    && grep -qx "=== PASS ===" "$log" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/pwm_tests.mem
// cmd_word u0 u1 v0 v1 w0 w1 expected_sum seed_flag, one record per line
// expected_sum is (u0+u1)*(v0+v1) mod 2^24, plus (w0+w1) for MAC, tag in cmd bits 7..0
00000001 000005 000007 000003 000004 0000aa 0000bb 000054 0
40000002 123456 edcbad abcdef 543215 001000 000234 001240 0
00000003 0f0f0f f100f2 000001 001000 ffffff 000001 002001 0
92345678 000000 000000 000000 000000 000000 000000 000000 1
40000004 ffffff 000003 000010 ffffff fffff0 000000 00000e 0
00000005 000080 000080 00ffff 000001 123456 654321 000000 0
40000006 000002 000001 555555 000000 000002 000000 000001 0
00000007 7fffff 800000 000001 000001 000abc 000def fffffe 0
40000008 000010 000001 000008 000009 000100 ffff00 000121 0
00000009 00000a fffffb 000006 000000 111111 222222 00001e 0
aaaaaaaa 000000 000000 000000 000000 000000 000000 000000 1
4000000b 000003 000004 000006 000000 000008 000000 000032 0
0000000c 000100 000000 000100 000000 00000f 0000f0 010000 0
4000000d 000002 000002 000005 000005 000001 000001 00002a 0
0000000e 000003 000004 000004 000005 00f00d 00beef 00003f 0
4000000f 000001 000000 ffffff 000000 000000 000001 000000 0
